// File: testbench/fpga_trace.txt
# B port last err | I cycles | C kind port value_hex | L led_mask_hex | T test_name
# kind: 0 beats, 1 frames, 2 errors, 3 drops
C 0 0 0
C 1 1 0
C 2 0 0
C 3 0 0
L 0
T reset_state
B 0 0 0
B 1 0 0
B 0 1 0
B 1 1 0
B 1 1 0
I 2
C 0 0 2
C 1 0 1
C 0 1 3
C 1 1 2
T frame_counting
B 0 0 1
B 0 1 1
B 1 1 1
I 2
C 0 0 4
C 1 0 2
C 2 0 1
C 2 1 1
C 1 1 3
T error_frames
B 2 1 0
B 3 0 0
I 2
C 3 1 2
C 0 1 4
C 1 2 0
C 0 3 0
T drops
I 12
L 0
B 1 1 0
I 2
L 2
I 12
L 0
T activity_leds

// File: files.f
+incdir+hw
hw/fpga_pkg.sv
hw/reset_sync.sv
hw/port_dispatch.sv
hw/port_monitor.sv
hw/stats_readout.sv
hw/fpga_core.sv
hw/fpga.sv
testbench/tb_fpga.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_fpga
FILE_LIST = files.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

// File: testbench/tb_fpga.sv
// Trace-driven testbench for the two-port Ethernet receive statistics design
`timescale 1ns/1ps

`include "fpga_defs.svh"

module tb_fpga import fpga_pkg::*; ();

logic                 clk;
logic                 rst_n;
eth_beat_t            rx_beat;
logic [3:0]           sw;
logic [`CNT_W-1:0]    stat_value;
logic [`PORT_CNT-1:0] led;
logic                 qsfp0_refclk_oe_b;
logic                 qsfp0_refclk_fs;
logic                 qsfp1_refclk_oe_b;
logic                 qsfp1_refclk_fs;

string trace_lines[$];
int    check_errs = 0;
int    tests_passed = 0;
int    tests_failed = 0;
int    cycle_cnt = 0;
int    cycle_limit = 1000000;

fpga uut (
    .clk_125mhz(clk),
    .rst_n(rst_n),
    .rx_beat(rx_beat),
    .sw(sw),
    .stat_value(stat_value),
    .led(led),
    .qsfp0_refclk_oe_b(qsfp0_refclk_oe_b),
    .qsfp0_refclk_fs(qsfp0_refclk_fs),
    .qsfp1_refclk_oe_b(qsfp1_refclk_oe_b),
    .qsfp1_refclk_fs(qsfp1_refclk_fs)
);

initial clk = 1'b0;
always #20 clk = ~clk;

// Run limit set from the trace length
always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
        $display("simulation timed out before the trace finished");
        $display("TESTBENCH FAILED");
        $finish;
    end
end

task automatic drive_beat(input int port, input int last, input int err);
    @(posedge clk);
    rx_beat <= '{valid: 1'b1, last: 1'(last), err: 1'(err), port: `PORT_W'(port),
                 data: {$urandom, $urandom}};
endtask

task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        rx_beat.valid <= 1'b0;
    end
endtask

// Switch change needs one cycle through the readout register
task automatic check_stat(input int kind, input int port, input logic [`CNT_W-1:0] exp);
    @(posedge clk);
    rx_beat.valid <= 1'b0;
    sw <= {2'(kind), 2'(port)};
    @(posedge clk);
    @(negedge clk);
    assert (stat_value === exp) else begin
        $display("CHECK FAILED: stat_value (kind %0d port %0d) expected %h got %h",
                 kind, port, exp, stat_value);
        check_errs++;
    end
endtask

task automatic check_led(input logic [`PORT_CNT-1:0] exp);
    @(posedge clk);
    rx_beat.valid <= 1'b0;
    @(negedge clk);
    assert (led === exp) else begin
        $display("CHECK FAILED: led expected %h got %h", exp, led);
        check_errs++;
    end
endtask

// Refclk enables low, frequency selects high
task automatic check_refclk();
    logic [3:0] got;
    got = {qsfp0_refclk_oe_b, qsfp0_refclk_fs, qsfp1_refclk_oe_b, qsfp1_refclk_fs};
    assert (got === 4'b0101) else begin
        $display("CHECK FAILED: qsfp refclk controls expected %h got %h", 4'b0101, got);
        check_errs++;
    end
endtask

task automatic close_test(input string name);
    if (check_errs == 0) begin
        tests_passed++;
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: %0d checks failed", name, check_errs);
    end
    check_errs = 0;
endtask

// Reads the trace and sums its cycles into the run limit
task automatic load_trace(output bit ok);
    int  fd;
    int  a;
    int  cycles;
    byte op;
    string line;
    fd = $fopen("testbench/fpga_trace.txt", "r");
    ok = (fd != 0);
    cycles = 50;
    if (ok) begin
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line.getc(0) != "#") begin
                trace_lines.push_back(line);
                a = 0;
                void'($sscanf(line, "%c %d", op, a));
                case (op)
                    "B": cycles += 1;
                    "I": cycles += a;
                    "C", "L": cycles += 2;
                    default: ;
                endcase
            end
        end
        $fclose(fd);
        cycle_limit = cycles;
    end
endtask

task automatic run_trace();
    int          a;
    int          b;
    int          c;
    byte         op;
    logic [31:0] value;
    string       line;
    string       name;
    foreach (trace_lines[i]) begin
        line = trace_lines[i];
        op = line.getc(0);
        case (op)
            "B": begin
                void'($sscanf(line, "%c %d %d %d", op, a, b, c));
                drive_beat(a, b, c);
            end
            "I": begin
                void'($sscanf(line, "%c %d", op, a));
                idle_cycles(a);
            end
            "C": begin
                void'($sscanf(line, "%c %d %d %h", op, a, b, value));
                check_stat(a, b, value[`CNT_W-1:0]);
            end
            "L": begin
                void'($sscanf(line, "%c %h", op, value));
                check_led(value[`PORT_CNT-1:0]);
            end
            "T": begin
                void'($sscanf(line, "%c %s", op, name));
                close_test(name);
            end
            default: begin
                $display("unknown command in the trace file: %s", line);
                check_errs++;
            end
        endcase
    end
endtask

initial begin
    bit ok;
    rst_n = 1'b0;
    rx_beat = '0;
    sw = '0;
    void'($urandom(9));
    load_trace(ok);
    if (!ok) begin
        $display("could not open the trace file testbench/fpga_trace.txt");
        $display("TESTBENCH FAILED");
        $finish;
    end else begin
        // Button reset for 2 cycles, then the synchronizer delay
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_refclk();
        run_trace();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && check_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end
end

endmodule

// File: hw/fpga.sv
// Board top level for the two-port Ethernet receive statistics design
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "fpga_defs.svh"

module fpga import fpga_pkg::*; (
    /*
     * Clock: 125 MHz from pin
     * Reset: push button, active low
     */
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_n,

    /*
     * MAC receive beats
     */
    input  wire eth_beat_t            rx_beat,

    /*
     * GPIO
     */
    input  wire logic [3:0]           sw,
    output wire logic [`CNT_W-1:0]    stat_value,
    output wire logic [`PORT_CNT-1:0] led,

    /*
     * QSFP28 reference clock control
     */
    output wire logic                 qsfp0_refclk_oe_b,
    output wire logic                 qsfp0_refclk_fs,
    output wire logic                 qsfp1_refclk_oe_b,
    output wire logic                 qsfp1_refclk_fs
);

// Button reset brought into the 125 MHz domain
wire rst_125mhz_n;

reset_sync #(
    .N(4)
)
sync_reset_125mhz_inst (
    .clk(clk_125mhz),
    .rst_in_n(rst_n),
    .rst_out_n(rst_125mhz_n)
);

// Refclk enabled, high frequency select
assign qsfp0_refclk_oe_b = 1'b0;
assign qsfp0_refclk_fs = 1'b1;
assign qsfp1_refclk_oe_b = 1'b0;
assign qsfp1_refclk_fs = 1'b1;

fpga_core core_inst (
    .clk_125mhz(clk_125mhz),
    .rst_n(rst_125mhz_n),
    .rx_beat(rx_beat),
    .sw(sw),
    .stat_value(stat_value),
    .led(led)
);

endmodule

`resetall

// File: hw/fpga_core.sv
// Receive statistics core with beat dispatch, per-port monitors and readout
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "fpga_defs.svh"

module fpga_core import fpga_pkg::*; (
    /*
     * Clock: 125 MHz
     * Synchronous reset, active low
     */
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_n,

    /*
     * MAC receive beats, tagged by port
     */
    input  wire eth_beat_t            rx_beat,

    /*
     * GPIO
     */
    input  wire logic [3:0]           sw,
    output wire logic [`CNT_W-1:0]    stat_value,
    output wire logic [`PORT_CNT-1:0] led
);

eth_beat_t         port_beat[`PORT_CNT];
port_stat_t        port_stat[`PORT_CNT];
wire [`CNT_W-1:0]  drop_cnt;

// Single input feeds all ports
port_dispatch dispatch_inst (
    .clk_125mhz(clk_125mhz),
    .rst_n(rst_n),
    .rx_beat(rx_beat),
    .port_beat(port_beat),
    .drop_cnt(drop_cnt)
);

// One monitor per Ethernet port
for (genvar n = 0; n < `PORT_CNT; n = n + 1) begin : port

    port_monitor monitor_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n(rst_n),
        .beat(port_beat[n]),
        .stat(port_stat[n])
    );

end

// All monitors drain into the readout
stats_readout readout_inst (
    .clk_125mhz(clk_125mhz),
    .rst_n(rst_n),
    .port_stat(port_stat),
    .drop_cnt(drop_cnt),
    .sw(sw),
    .stat_value(stat_value),
    .led(led)
);

endmodule

`resetall

// File: hw/stats_readout.sv
// Switch-selected statistics readout and per-port activity LED register
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "fpga_defs.svh"

module stats_readout import fpga_pkg::*; (
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_n,

    // Monitor status and dispatcher drops
    input  wire port_stat_t           port_stat[`PORT_CNT],
    input  wire logic [`CNT_W-1:0]    drop_cnt,

    // sw[1:0] port index, sw[3:2] counter kind
    input  wire logic [3:0]           sw,

    output wire logic [`CNT_W-1:0]    stat_value,
    output wire logic [`PORT_CNT-1:0] led
);

logic [1:0]           port_idx;
stat_sel_e            stat_sel;
port_stat_t           sel_stat;
logic [`CNT_W-1:0]    stat_value_next;

logic [`CNT_W-1:0]    stat_value_reg;
logic [`PORT_CNT-1:0] led_reg;

assign port_idx = sw[1:0];
assign stat_sel = stat_sel_e'(sw[3:2]);

always_comb begin
    // Missing port reads as all zero
    sel_stat = '0;
    for (int i = 0; i < `PORT_CNT; i++) begin
        if (port_idx == 2'(i)) begin
            sel_stat = port_stat[i];
        end
    end

    stat_value_next = '0;
    case (stat_sel)
        STAT_BEATS:  stat_value_next = sel_stat.beat_cnt;
        STAT_FRAMES: stat_value_next = sel_stat.frame_cnt;
        STAT_ERRORS: stat_value_next = sel_stat.err_cnt;
        STAT_DROPS:  stat_value_next = drop_cnt;
    endcase
end

always_ff @(posedge clk_125mhz) begin
    stat_value_reg <= stat_value_next;
    for (int i = 0; i < `PORT_CNT; i++) begin
        led_reg[i] <= port_stat[i].act;
    end

    if (!rst_n) begin
        stat_value_reg <= '0;
        led_reg <= '0;
    end
end

assign stat_value = stat_value_reg;
assign led = led_reg;

endmodule

`resetall

// File: hw/port_monitor.sv
// Per-port receive statistics with beat, frame and errored frame counts and activity
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "fpga_defs.svh"

module port_monitor import fpga_pkg::*; (
    input  wire logic       clk_125mhz,
    input  wire logic       rst_n,

    // Routed beat for this port
    input  wire eth_beat_t  beat,

    // Counters and stretched activity
    output wire port_stat_t stat
);

// Wide enough to hold the full stretch length
localparam ACT_W = $clog2(`ACT_STRETCH + 1);

logic [`CNT_W-1:0] beat_cnt_reg;
logic [`CNT_W-1:0] frame_cnt_reg;
logic [`CNT_W-1:0] err_cnt_reg;
logic [ACT_W-1:0]  act_cnt_reg;

logic              frame_end;
logic              frame_bad;

assign frame_end = beat.valid && beat.last;

// Error only counts when flagged on the closing beat
assign frame_bad = frame_end && beat.err;

always_ff @(posedge clk_125mhz) begin
    if (beat.valid) begin
        beat_cnt_reg <= sat_inc(beat_cnt_reg);
    end

    if (frame_end) begin
        frame_cnt_reg <= sat_inc(frame_cnt_reg);
    end

    if (frame_bad) begin
        err_cnt_reg <= sat_inc(err_cnt_reg);
    end

    // Reload on traffic, otherwise run down to zero
    if (beat.valid) begin
        act_cnt_reg <= ACT_W'(`ACT_STRETCH);
    end else if (act_cnt_reg != '0) begin
        act_cnt_reg <= act_cnt_reg - 1'b1;
    end

    if (!rst_n) begin
        beat_cnt_reg <= '0;
        frame_cnt_reg <= '0;
        err_cnt_reg <= '0;
        act_cnt_reg <= '0;
    end
end

assign stat = '{
    beat_cnt:  beat_cnt_reg,
    frame_cnt: frame_cnt_reg,
    err_cnt:   err_cnt_reg,
    act:       (act_cnt_reg != '0)
};

endmodule

`resetall

// File: hw/port_dispatch.sv
// Receive beat router that forwards each tagged beat to its port monitor
`resetall
`timescale 1ns/1ps
`default_nettype none

`include "fpga_defs.svh"

module port_dispatch import fpga_pkg::*; (
    input  wire logic              clk_125mhz,
    input  wire logic              rst_n,

    // Tagged beat from the MAC side
    input  wire eth_beat_t         rx_beat,

    // One registered beat per port
    output wire eth_beat_t         port_beat[`PORT_CNT],
    output wire logic [`CNT_W-1:0] drop_cnt
);

eth_beat_t         port_beat_reg[`PORT_CNT];
logic [`CNT_W-1:0] drop_cnt_reg;
logic              tag_bad;

// Tag names a port that does not exist
assign tag_bad = int'(rx_beat.port) >= `PORT_CNT;

always_ff @(posedge clk_125mhz) begin
    // Payload goes to every port, valid only to the addressed one
    for (int i = 0; i < `PORT_CNT; i++) begin
        port_beat_reg[i] <= rx_beat;
        port_beat_reg[i].valid <= rx_beat.valid && (rx_beat.port == `PORT_W'(i));
    end

    if (rx_beat.valid && tag_bad) begin
        drop_cnt_reg <= sat_inc(drop_cnt_reg);
    end

    if (!rst_n) begin
        for (int i = 0; i < `PORT_CNT; i++) begin
            port_beat_reg[i].valid <= 1'b0;
        end
        drop_cnt_reg <= '0;
    end
end

assign port_beat = port_beat_reg;
assign drop_cnt = drop_cnt_reg;

endmodule

`resetall

// File: hw/reset_sync.sv
// Reset synchronizer producing a clean synchronous active-low reset from a button
`resetall
`timescale 1ns/1ps
`default_nettype none

module reset_sync #(
    // Number of register stages, 2 or more
    parameter N = 4
) (
    input  wire logic clk,
    input  wire logic rst_in_n,
    output wire logic rst_out_n
);

logic [N-1:0] sync_reg;

// Clears on the first low sample, then shifts ones in
always_ff @(posedge clk) begin
    if (!rst_in_n) begin
        sync_reg <= '0;
    end else begin
        sync_reg <= {sync_reg[N-2:0], 1'b1};
    end
end

assign rst_out_n = sync_reg[N-1];

endmodule

`resetall

// File: hw/fpga_pkg.sv
// Shared receive beat, port status and readout select types for the core
`include "fpga_defs.svh"

package fpga_pkg;

    // One MAC receive beat with its port tag
    typedef struct packed {
        logic                   valid;
        logic                   last;
        logic                   err;
        logic [`PORT_W-1:0]     port;
        logic [`MAC_DATA_W-1:0] data;
    } eth_beat_t;

    // Per-port statistics and activity
    typedef struct packed {
        logic [`CNT_W-1:0] beat_cnt;
        logic [`CNT_W-1:0] frame_cnt;
        logic [`CNT_W-1:0] err_cnt;
        logic              act;
    } port_stat_t;

    // Counter kind, taken from the upper switch pair
    typedef enum logic [1:0] {
        STAT_BEATS  = 2'd0,
        STAT_FRAMES = 2'd1,
        STAT_ERRORS = 2'd2,
        STAT_DROPS  = 2'd3
    } stat_sel_e;

    // Counter increment that holds at all ones
    function automatic logic [`CNT_W-1:0] sat_inc(input logic [`CNT_W-1:0] value);
        return (value == '1) ? value : value + 1'b1;
    endfunction

endpackage

// File: hw/fpga_defs.svh
// Sizing constants shared by the two-port Ethernet receive monitor
`ifndef FPGA_DEFS_SVH
`define FPGA_DEFS_SVH

// Ethernet ports on the board
`define PORT_CNT 2

// Port tag width, one bit more than the port count needs so bad tags can arrive
`define PORT_W 2

// MAC receive data path width
`define MAC_DATA_W 64

// Statistics counters, saturating at all ones
`define CNT_W 16

// Activity LED hold time in clock cycles
`define ACT_STRETCH 8

`endif
